// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  typedef logic [15:0] seg_t;
  typedef logic [15:0] ofs_t;
  typedef logic [19:0] phys_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  ilen_t;  // saturates at 15

  typedef enum logic [2:0] {
    st_opcode,
    st_modrm,
    st_disp_lo,
    st_disp_hi,
    st_imm_lo,
    st_imm_hi
  } instr_state_e;

  typedef enum logic [3:0] {
    cls_alu,
    cls_alu_imm,
    cls_mov,
    cls_mov_imm,
    cls_incdec,
    cls_pushpop,
    cls_jcc,
    cls_jmp,
    cls_call,
    cls_ret,
    cls_nop,
    cls_hlt,
    cls_illegal
  } instr_class_e;

  // opcodes named by the decoder tables
  localparam byte_t op_nop      = 8'h90;
  localparam byte_t op_hlt      = 8'hf4;
  localparam byte_t op_ret      = 8'hc3;
  localparam byte_t op_call     = 8'he8;
  localparam byte_t op_jmp16    = 8'he9;
  localparam byte_t op_jmp8     = 8'heb;
  localparam byte_t op_grp83    = 8'h83;
  localparam byte_t op_rep_base = 8'hf2;  // f2 repnz, f3 repz

  // 26/2e/36/3e share 001x_x110, bits 4:3 select the segment
  localparam byte_t seg_prefix_mask = 8'he7;
  localparam byte_t seg_prefix_base = 8'h26;

  localparam byte_t reset_modrm = 8'b00_000_110;  // mod 00, rm 110

  typedef struct packed {
    byte_t      data;
    phys_addr_t addr;
  } fetch_byte_t;

  typedef struct packed {
    byte_t      opcode;
    byte_t      modrm;
    logic       has_modrm;
    ofs_t       disp;       // already sign-extended
    ofs_t       imm;
    logic       rep_valid;
    logic       rep_z;
    logic       seg_valid;
    logic [1:0] seg_sel;
    phys_addr_t start_addr;
    ilen_t      len;
  } raw_instr_t;

  typedef struct packed {
    instr_class_e cls;
    logic [2:0]   alu_op;
    logic         word;
    logic         dir;
    logic [2:0]   reg_f;
    logic [2:0]   rm_f;
    logic [1:0]   mod_f;
    ofs_t         disp;
    ofs_t         imm;
    logic         rep_valid;
    logic         rep_z;
    logic         seg_valid;
    logic [1:0]   seg_sel;
    phys_addr_t   start_addr;
    ilen_t        len;
  } decoded_instr_t;

endpackage

`default_nettype wire

// ==== src/opcode_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_classify (
  input  fetch_pkg::byte_t opcode,
  input  fetch_pkg::byte_t modrm,
  output logic             is_seg_prefix,
  output logic             is_rep_prefix,
  output logic             need_modrm,
  output logic             need_disp,
  output logic             disp_word,
  output logic             need_imm,
  output logic             imm_word,
  output logic             imm_sext
);

  assign is_seg_prefix = (opcode & fetch_pkg::seg_prefix_mask) == fetch_pkg::seg_prefix_base;
  assign is_rep_prefix = (opcode & 8'hfe) == fetch_pkg::op_rep_base;

  // extra bytes implied by the opcode
  always_comb
  begin
    need_modrm = 1'b0;
    need_imm   = 1'b0;
    imm_word   = 1'b0;
    imm_sext   = 1'b0;
    casez (opcode)
      8'b00???0??:  // alu reg/rm
        need_modrm = 1'b1;
      8'b00???10?:  // alu al/ax, imm
      begin
        need_imm = 1'b1;
        imm_word = opcode[0];
      end
      8'b0111_????:  // jcc rel8
      begin
        need_imm = 1'b1;
        imm_sext = 1'b1;
      end
      8'h80:
      begin
        need_modrm = 1'b1;
        need_imm   = 1'b1;
      end
      8'h81:
      begin
        need_modrm = 1'b1;
        need_imm   = 1'b1;
        imm_word   = 1'b1;
      end
      fetch_pkg::op_grp83:
      begin
        need_modrm = 1'b1;
        need_imm   = 1'b1;
        imm_sext   = 1'b1;
      end
      8'b1000_10??:  // mov reg/rm
        need_modrm = 1'b1;
      8'b1011_????:  // mov reg, imm; bit 3 is the width
      begin
        need_imm = 1'b1;
        imm_word = opcode[3];
      end
      fetch_pkg::op_call, fetch_pkg::op_jmp16:
      begin
        need_imm = 1'b1;
        imm_word = 1'b1;
      end
      fetch_pkg::op_jmp8:
      begin
        need_imm = 1'b1;
        imm_sext = 1'b1;
      end
      default: ;  // no extra bytes, illegal opcodes included
    endcase
  end

  // displacement from mod/rm
  always_comb
  begin
    need_disp = 1'b0;
    disp_word = 1'b0;
    if (need_modrm)
    begin
      case (modrm[7:6])
        2'b00:
          if (modrm[2:0] == 3'b110)  // direct address
          begin
            need_disp = 1'b1;
            disp_word = 1'b1;
          end
        2'b01:
          need_disp = 1'b1;
        2'b10:
        begin
          need_disp = 1'b1;
          disp_word = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/byte_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fetch (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  fetch_pkg::seg_t       start_cs,
  input  fetch_pkg::ofs_t       start_ip,
  input  logic                  mem_valid,
  input  fetch_pkg::byte_t      mem_data,
  output logic                  mem_req,
  output fetch_pkg::phys_addr_t mem_addr,
  output logic                  byte_valid,
  output fetch_pkg::fetch_byte_t fbyte
);

  fetch_pkg::phys_addr_t addr;  // address of the next byte to request
  logic pending;                // request out, response not yet back
  logic stale;                  // pending response belongs to the old stream

  assign mem_addr = addr;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_req    <= 1'b0;
      pending    <= 1'b0;
      stale      <= 1'b0;
      byte_valid <= 1'b0;
    end
    else
    begin
      mem_req    <= 1'b0;
      byte_valid <= 1'b0;
      if (mem_req)
        pending <= 1'b1;
      if (start)
      begin
        if (mem_valid)
          pending <= 1'b0;  // old byte, dropped
        // wait for an outstanding response before the new request
        if (mem_req || (pending && !mem_valid))
          stale <= 1'b1;
        else
        begin
          stale   <= 1'b0;
          mem_req <= 1'b1;
        end
      end
      else if (mem_valid)
      begin
        pending <= 1'b0;
        mem_req <= 1'b1;   // next byte, or the deferred restart request
        if (stale)
          stale <= 1'b0;
        else
          byte_valid <= 1'b1;
      end
    end
  end

  // running address and the byte handed to the assembler
  always_ff @(posedge clk)
  begin
    if (start)
      addr <= {start_cs, 4'h0} + {4'h0, start_ip};
    else if (mem_valid && !stale)
    begin
      fbyte.data <= mem_data;
      fbyte.addr <= addr;
      addr       <= addr + 20'd1;
    end
  end

endmodule

`default_nettype wire

// ==== src/instr_assemble.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_assemble (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   byte_valid,
  input  fetch_pkg::fetch_byte_t fbyte,
  output logic                   raw_valid,
  output fetch_pkg::raw_instr_t  raw
);

  fetch_pkg::instr_state_e state;
  fetch_pkg::instr_state_e nxt_state;
  fetch_pkg::raw_instr_t   cur;      // instruction collected so far
  fetch_pkg::raw_instr_t   nxt;      // cur with the incoming byte merged
  fetch_pkg::raw_instr_t   cleared;
  logic                    last;     // incoming byte ends the instruction

  fetch_pkg::byte_t cls_opcode;
  fetch_pkg::byte_t cls_modrm;
  logic is_seg_prefix;
  logic is_rep_prefix;
  logic need_modrm;
  logic need_disp;
  logic disp_word;
  logic need_imm;
  logic imm_word;
  logic imm_sext;

  // classify the byte in flight until the opcode and mod/rm are latched
  assign cls_opcode = (state == fetch_pkg::st_opcode) ? fbyte.data : cur.opcode;
  assign cls_modrm  = (state == fetch_pkg::st_modrm) ? fbyte.data : cur.modrm;

  opcode_classify u_classify (
    .opcode        (cls_opcode),
    .modrm         (cls_modrm),
    .is_seg_prefix (is_seg_prefix),
    .is_rep_prefix (is_rep_prefix),
    .need_modrm    (need_modrm),
    .need_disp     (need_disp),
    .disp_word     (disp_word),
    .need_imm      (need_imm),
    .imm_word      (imm_word),
    .imm_sext      (imm_sext)
  );

  always_comb
  begin
    cleared       = '0;
    cleared.modrm = fetch_pkg::reset_modrm;
  end

  always_comb
  begin
    nxt       = cur;
    nxt_state = state;
    last      = 1'b0;
    nxt.len   = (&cur.len) ? cur.len : cur.len + 4'd1;
    if (cur.len == 4'd0)
      nxt.start_addr = fbyte.addr;  // first prefix or the opcode
    case (state)
      fetch_pkg::st_opcode:
        if (is_seg_prefix)
        begin
          nxt.seg_valid = 1'b1;
          nxt.seg_sel   = fbyte.data[4:3];
        end
        else if (is_rep_prefix)
        begin
          nxt.rep_valid = 1'b1;
          nxt.rep_z     = fbyte.data[0];
        end
        else
        begin
          nxt.opcode    = fbyte.data;
          nxt.has_modrm = need_modrm;
          if (need_modrm)
            nxt_state = fetch_pkg::st_modrm;
          else if (need_imm)
            nxt_state = fetch_pkg::st_imm_lo;
          else
            last = 1'b1;
        end
      fetch_pkg::st_modrm:
      begin
        nxt.modrm = fbyte.data;
        if (need_disp)
          nxt_state = fetch_pkg::st_disp_lo;
        else if (need_imm)
          nxt_state = fetch_pkg::st_imm_lo;
        else
          last = 1'b1;
      end
      fetch_pkg::st_disp_lo:
      begin
        nxt.disp = {{8{fbyte.data[7]}}, fbyte.data};  // disp8 always sign-extended
        if (disp_word)
          nxt_state = fetch_pkg::st_disp_hi;
        else if (need_imm)
          nxt_state = fetch_pkg::st_imm_lo;
        else
          last = 1'b1;
      end
      fetch_pkg::st_disp_hi:
      begin
        nxt.disp[15:8] = fbyte.data;
        if (need_imm)
          nxt_state = fetch_pkg::st_imm_lo;
        else
          last = 1'b1;
      end
      fetch_pkg::st_imm_lo:
      begin
        nxt.imm = {{8{imm_sext & fbyte.data[7]}}, fbyte.data};
        if (imm_word)
          nxt_state = fetch_pkg::st_imm_hi;
        else
          last = 1'b1;
      end
      default:  // st_imm_hi
      begin
        nxt.imm[15:8] = fbyte.data;
        last          = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst || start)
    begin
      state     <= fetch_pkg::st_opcode;
      cur       <= cleared;  // drops prefixes and any partial instruction
      raw_valid <= 1'b0;
    end
    else
    begin
      raw_valid <= byte_valid && last;
      if (byte_valid)
      begin
        if (last)
        begin
          state <= fetch_pkg::st_opcode;
          cur   <= cleared;
        end
        else
        begin
          state <= nxt_state;
          cur   <= nxt;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_valid && last)
      raw <= nxt;
  end

endmodule

`default_nettype wire

// ==== src/micro_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module micro_decode (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic                      raw_valid,
  input  fetch_pkg::raw_instr_t     raw,
  output logic                      dec_valid,
  output fetch_pkg::decoded_instr_t dec
);

  fetch_pkg::decoded_instr_t d;
  fetch_pkg::byte_t          op;
  fetch_pkg::byte_t          mrm;
  logic                      grp;   // 80/81/83, operation in mod/rm reg

  assign op  = raw.opcode;
  assign mrm = raw.has_modrm ? raw.modrm : fetch_pkg::reset_modrm;
  assign grp = (op[7:2] == 6'b1000_00) && (op[1:0] != 2'b10);

  always_comb
  begin
    casez (op)
      8'b00???0??:                 d.cls = fetch_pkg::cls_alu;
      8'b00???10?:                 d.cls = fetch_pkg::cls_alu_imm;
      8'b0100_????:                d.cls = fetch_pkg::cls_incdec;
      8'b0101_????:                d.cls = fetch_pkg::cls_pushpop;
      8'b0111_????:                d.cls = fetch_pkg::cls_jcc;
      8'h80, 8'h81, fetch_pkg::op_grp83:
                                   d.cls = fetch_pkg::cls_alu_imm;
      8'b1000_10??:                d.cls = fetch_pkg::cls_mov;
      fetch_pkg::op_nop:           d.cls = fetch_pkg::cls_nop;
      8'b1011_????:                d.cls = fetch_pkg::cls_mov_imm;
      fetch_pkg::op_ret:           d.cls = fetch_pkg::cls_ret;
      fetch_pkg::op_call:          d.cls = fetch_pkg::cls_call;
      fetch_pkg::op_jmp16, fetch_pkg::op_jmp8:
                                   d.cls = fetch_pkg::cls_jmp;
      fetch_pkg::op_hlt:           d.cls = fetch_pkg::cls_hlt;
      default:                     d.cls = fetch_pkg::cls_illegal;
    endcase

    d.alu_op = grp ? mrm[5:3] : op[5:3];
    d.word   = (op[7:4] == 4'hb) ? op[3] : op[0];
    d.dir    = raw.has_modrm & op[1];
    d.mod_f  = mrm[7:6];
    d.rm_f   = mrm[2:0];
    // register number sits in the opcode for 40-5f and b0-bf
    if (op[7:5] == 3'b010 || op[7:4] == 4'hb)
      d.reg_f = op[2:0];
    else
      d.reg_f = mrm[5:3];

    d.disp       = raw.disp;
    d.imm        = raw.imm;
    d.rep_valid  = raw.rep_valid;
    d.rep_z      = raw.rep_z;
    d.seg_valid  = raw.seg_valid;
    d.seg_sel    = raw.seg_sel;
    d.start_addr = raw.start_addr;
    d.len        = raw.len;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid <= 1'b0;
    else
      dec_valid <= raw_valid && !start;  // flush on restart
  end

  always_ff @(posedge clk)
  begin
    if (raw_valid)
      dec <= d;
  end

endmodule

`default_nettype wire

// ==== src/fetch_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  fetch_pkg::seg_t           start_cs,
  input  fetch_pkg::ofs_t           start_ip,
  input  logic                      mem_valid,
  input  fetch_pkg::byte_t          mem_data,
  output logic                      mem_req,
  output fetch_pkg::phys_addr_t     mem_addr,
  output logic                      dec_valid,
  output fetch_pkg::decoded_instr_t dec
);

  logic                   byte_valid;
  fetch_pkg::fetch_byte_t fbyte;
  logic                   raw_valid;
  fetch_pkg::raw_instr_t  raw;

  byte_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .start_cs   (start_cs),
    .start_ip   (start_ip),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .byte_valid (byte_valid),
    .fbyte      (fbyte)
  );

  // start also flushes the two later stages
  instr_assemble u_assemble (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .byte_valid (byte_valid),
    .fbyte      (fbyte),
    .raw_valid  (raw_valid),
    .raw        (raw)
  );

  micro_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .raw_valid (raw_valid),
    .raw       (raw),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

endmodule

`default_nettype wire

// ==== verification/fetch_decode_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_sva (
  input wire logic clk,
  input wire logic rst,
  input wire logic start,
  input wire logic mem_req,
  input wire logic mem_valid,
  input wire logic byte_valid,
  input wire logic raw_valid,
  input wire logic dec_valid
);

  logic outstanding;  // request sent, no response yet
  int failures = 0;   // failed assertions so far

  always_ff @(posedge clk)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (mem_req)
      outstanding <= 1'b1;
    else if (mem_valid)
      outstanding <= 1'b0;
  end

  a_reset_quiet: assert property (@(posedge clk)
    $past(rst) |-> !mem_req && !byte_valid && !raw_valid && !dec_valid)
    else
    begin
      $error("strobe active during reset");
      failures++;
    end

  a_one_request: assert property (@(posedge clk) disable iff (rst)
    mem_req |-> !outstanding)
    else
    begin
      $error("mem_req while a request is outstanding");
      failures++;
    end

  a_dec_follows_raw: assert property (@(posedge clk) disable iff (rst)
    raw_valid && !start |=> dec_valid)
    else
    begin
      $error("dec_valid missing after raw_valid");
      failures++;
    end

  a_dec_has_raw: assert property (@(posedge clk) disable iff (rst)
    dec_valid |-> $past(raw_valid))
    else
    begin
      $error("dec_valid without raw_valid one cycle before");
      failures++;
    end

endmodule

bind fetch_decode_top fetch_decode_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .start      (start),
  .mem_req    (mem_req),
  .mem_valid  (mem_valid),
  .byte_valid (byte_valid),
  .raw_valid  (raw_valid),
  .dec_valid  (dec_valid)
);

`default_nettype wire

// ==== verification/fetch_decode_ref.svh ====
`ifndef FETCH_DECODE_REF_SVH
`define FETCH_DECODE_REF_SVH

// expected record for the instruction starting at a, and its length in bytes
function automatic void ref_decode(input fetch_pkg::byte_t m [0:1023],
                                   input fetch_pkg::phys_addr_t a,
                                   output fetch_pkg::decoded_instr_t e,
                                   output int n);
  fetch_pkg::byte_t op;
  fetch_pkg::byte_t mrm;
  logic has_mrm;
  logic sx;
  int disp_n;
  int imm_n;
  e = '0;
  n = 0;
  has_mrm = 1'b0;
  sx = 1'b0;
  disp_n = 0;
  imm_n = 0;
  e.start_addr = a;
  op = m[10'(a)];
  while (op == 8'h26 || op == 8'h2e || op == 8'h36 || op == 8'h3e ||
         op == 8'hf2 || op == 8'hf3)
  begin
    if (op[7:4] == 4'hf)
    begin
      e.rep_valid = 1'b1;
      e.rep_z     = op[0];  // later prefix overrides
    end
    else
    begin
      e.seg_valid = 1'b1;
      e.seg_sel   = op[4:3];
    end
    n++;
    op = m[10'(a + n)];
  end
  e.cls = fetch_pkg::cls_illegal;
  if (op < 8'h40 && op[2] == 1'b0)
  begin
    e.cls = fetch_pkg::cls_alu;
    has_mrm = 1'b1;
  end
  else if (op < 8'h40 && op[2:1] == 2'b10)
  begin
    e.cls = fetch_pkg::cls_alu_imm;
    imm_n = op[0] ? 2 : 1;
  end
  else if (op >= 8'h40 && op <= 8'h4f)
    e.cls = fetch_pkg::cls_incdec;
  else if (op >= 8'h50 && op <= 8'h5f)
    e.cls = fetch_pkg::cls_pushpop;
  else if (op >= 8'h70 && op <= 8'h7f)
  begin
    e.cls = fetch_pkg::cls_jcc;
    imm_n = 1;
    sx = 1'b1;
  end
  else if (op == 8'h80 || op == 8'h81 || op == 8'h83)
  begin
    e.cls = fetch_pkg::cls_alu_imm;
    has_mrm = 1'b1;
    imm_n = (op == 8'h81) ? 2 : 1;
    sx = (op == 8'h83);
  end
  else if (op >= 8'h88 && op <= 8'h8b)
  begin
    e.cls = fetch_pkg::cls_mov;
    has_mrm = 1'b1;
  end
  else if (op == 8'h90)
    e.cls = fetch_pkg::cls_nop;
  else if (op >= 8'hb0 && op <= 8'hbf)
  begin
    e.cls = fetch_pkg::cls_mov_imm;
    imm_n = op[3] ? 2 : 1;
  end
  else if (op == 8'hc3)
    e.cls = fetch_pkg::cls_ret;
  else if (op == 8'he8 || op == 8'he9)
  begin
    e.cls = (op == 8'he8) ? fetch_pkg::cls_call : fetch_pkg::cls_jmp;
    imm_n = 2;
  end
  else if (op == 8'heb)
  begin
    e.cls = fetch_pkg::cls_jmp;
    imm_n = 1;
    sx = 1'b1;
  end
  else if (op == 8'hf4)
    e.cls = fetch_pkg::cls_hlt;
  n++;  // opcode
  mrm = fetch_pkg::reset_modrm;
  if (has_mrm)
  begin
    mrm = m[10'(a + n)];
    n++;
    if (mrm[7:6] == 2'b01)
      disp_n = 1;
    else if (mrm[7:6] == 2'b10 || (mrm[7:6] == 2'b00 && mrm[2:0] == 3'b110))
      disp_n = 2;
  end
  if (disp_n > 0)
  begin
    e.disp = {{8{m[10'(a + n)][7]}}, m[10'(a + n)]};  // disp8 always sign-extended
    if (disp_n == 2)
      e.disp[15:8] = m[10'(a + n + 1)];
    n += disp_n;
  end
  if (imm_n > 0)
  begin
    e.imm = {{8{sx & m[10'(a + n)][7]}}, m[10'(a + n)]};
    if (imm_n == 2)
      e.imm[15:8] = m[10'(a + n + 1)];
    n += imm_n;
  end
  e.alu_op = (op == 8'h80 || op == 8'h81 || op == 8'h83) ? mrm[5:3] : op[5:3];
  e.word   = (op[7:4] == 4'hb) ? op[3] : op[0];
  e.dir    = has_mrm & op[1];
  e.mod_f  = mrm[7:6];
  e.rm_f   = mrm[2:0];
  e.reg_f  = ((op >= 8'h40 && op <= 8'h5f) || op[7:4] == 4'hb) ? op[2:0] : mrm[5:3];
  e.len    = (n > 15) ? 4'd15 : 4'(n);
endfunction

`endif

// ==== verification/fetch_decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_tb;

  localparam int total_bytes = 105 + 200 * 7;
  localparam int cycle_limit = total_bytes * 5 + 3000;  // 5 cycles per byte worst case

  logic clk;
  logic rst;
  logic start;
  fetch_pkg::seg_t start_cs;
  fetch_pkg::ofs_t start_ip;
  logic mem_valid;
  fetch_pkg::byte_t mem_data;
  logic mem_req;
  fetch_pkg::phys_addr_t mem_addr;
  logic dec_valid;
  fetch_pkg::decoded_instr_t dec;

  fetch_pkg::byte_t mem [0:1023];
  logic [31:0] lat_rng = 32'h2b157d9e;
  logic [31:0] gen_rng = 32'h2b157d9e ^ 32'h5a5a5a5a;
  logic mem_busy;
  int mem_cnt;
  fetch_pkg::phys_addr_t mem_paddr;

  string test_name = "none";
  logic checking;
  fetch_pkg::phys_addr_t exp_addr;
  fetch_pkg::decoded_instr_t exp_dec;
  int exp_len;
  int dec_count;
  int test_errors;
  int errors;
  int checks;
  int tests;
  int cycles;
  fetch_pkg::byte_t prog[$];

  fetch_decode_top DUT (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .start_cs  (start_cs),
    .start_ip  (start_ip),
    .mem_valid (mem_valid),
    .mem_data  (mem_data),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  `include "fetch_decode_ref.svh"

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // byte memory, one request at a time, 1 to 4 cycles latency
  always @(posedge clk)
  begin
    mem_valid <= 1'b0;
    if (mem_req)
    begin
      lat_rng = xorshift(lat_rng);
      if (lat_rng[1:0] == 2'd0)
      begin
        mem_valid <= 1'b1;
        mem_data  <= mem[mem_addr[9:0]];
      end
      else
      begin
        mem_busy  <= 1'b1;
        mem_cnt   <= lat_rng[1:0];
        mem_paddr <= mem_addr;
      end
    end
    else if (mem_busy)
    begin
      if (mem_cnt == 1)
      begin
        mem_valid <= 1'b1;
        mem_data  <= mem[mem_paddr[9:0]];
        mem_busy  <= 1'b0;
      end
      else
        mem_cnt <= mem_cnt - 1;
    end
  end

  task automatic check_field(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (exp_v === act_v)
    else
    begin
      $display("** Error %s: %s expected %h actual %h", test_name, field, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  // compare process, restart moves the expected address
  always @(posedge clk)
  begin
    if (start)
      exp_addr = {start_cs, 4'h0} + {4'h0, start_ip};
    else if (dec_valid && checking)
    begin
      ref_decode(mem, exp_addr, exp_dec, exp_len);
      check_field("cls", exp_dec.cls, dec.cls);
      check_field("alu_op", exp_dec.alu_op, dec.alu_op);
      check_field("word", exp_dec.word, dec.word);
      check_field("dir", exp_dec.dir, dec.dir);
      check_field("reg_f", exp_dec.reg_f, dec.reg_f);
      check_field("rm_f", exp_dec.rm_f, dec.rm_f);
      check_field("mod_f", exp_dec.mod_f, dec.mod_f);
      check_field("disp", exp_dec.disp, dec.disp);
      check_field("imm", exp_dec.imm, dec.imm);
      check_field("rep_valid", exp_dec.rep_valid, dec.rep_valid);
      check_field("rep_z", exp_dec.rep_z, dec.rep_z);
      check_field("seg_valid", exp_dec.seg_valid, dec.seg_valid);
      check_field("seg_sel", exp_dec.seg_sel, dec.seg_sel);
      check_field("start_addr", exp_dec.start_addr, dec.start_addr);
      check_field("len", exp_dec.len, dec.len);
      exp_addr = exp_addr + exp_len;
      dec_count++;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("timeout after %0d cycles, decoded stream never completed", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic put(inout fetch_pkg::phys_addr_t a, input fetch_pkg::byte_t b);
    mem[a[9:0]] = b;
    a = a + 20'd1;
  endtask

  task automatic load(input fetch_pkg::phys_addr_t a);
    foreach (prog[i])
      put(a, prog[i]);
  endtask

  task automatic begin_test(input string name);
    @(posedge clk);
    checking <= 1'b0;  // old stream keeps running unchecked
    @(posedge clk);
    test_name = name;
    test_errors = 0;
    dec_count = 0;
  endtask

  task automatic launch_now(input fetch_pkg::seg_t cs, input fetch_pkg::ofs_t ip);
    start    <= 1'b1;
    start_cs <= cs;
    start_ip <= ip;
    checking <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic finish_test(input int n);
    while (dec_count < n)
      @(posedge clk);
    $display("test %s: %0d instructions, %0d errors", test_name, dec_count, test_errors);
    tests++;
  endtask

  // one well-formed instruction of the subset, with an optional prefix
  task automatic gen_instr(inout fetch_pkg::phys_addr_t a);
    logic [31:0] r;
    logic [31:0] d;
    fetch_pkg::byte_t op;
    fetch_pkg::byte_t mrm;
    logic mod_form;
    int imm_n;
    gen_rng = xorshift(gen_rng);
    r = gen_rng;
    gen_rng = xorshift(gen_rng);
    d = gen_rng;
    mod_form = 1'b0;
    imm_n = 0;
    if (r[31:30] == 2'd0)
      put(a, (r[29]) ? {7'b1111_001, r[28]} : {3'b001, r[28:27], 3'b110});
    case (r[3:0] % 10)
      0:
      begin
        op = {2'b00, r[6:4], 1'b0, r[8:7]};
        mod_form = 1'b1;
      end
      1:
      begin
        op = {2'b00, r[6:4], 2'b10, r[7]};
        imm_n = r[7] ? 2 : 1;
      end
      2: op = 8'h40 + r[8:4];
      3:
      begin
        op = {4'h7, r[7:4]};
        imm_n = 1;
      end
      4:
      begin
        op = (r[5:4] == 0) ? 8'h80 : (r[5:4] == 1) ? 8'h81 : 8'h83;
        mod_form = 1'b1;
        imm_n = (op == 8'h81) ? 2 : 1;
      end
      5:
      begin
        op = {6'b1000_10, r[5:4]};
        mod_form = 1'b1;
      end
      6:
      begin
        op = {4'hb, r[7:4]};
        imm_n = r[7] ? 2 : 1;
      end
      7: op = (r[5:4] == 0) ? 8'h90 : (r[5:4] == 1) ? 8'hc3 : 8'hf4;
      8:
      begin
        op = (r[5:4] == 0) ? 8'he8 : (r[5:4] == 1) ? 8'he9 : 8'heb;
        imm_n = (op == 8'heb) ? 1 : 2;
      end
      default: op = (r[5:4] == 0) ? 8'h0f : (r[5:4] == 1) ? 8'h82 : 8'hff;  // illegal
    endcase
    put(a, op);
    if (mod_form)
    begin
      mrm = r[23:16];
      put(a, mrm);
      if (mrm[7:6] == 2'b01)
        put(a, d[7:0]);
      else if (mrm[7:6] == 2'b10 || (mrm[7:6] == 2'b00 && mrm[2:0] == 3'b110))
      begin
        put(a, d[7:0]);
        put(a, d[15:8]);
      end
    end
    if (imm_n > 0)
      put(a, d[23:16]);
    if (imm_n > 1)
      put(a, d[31:24]);
  endtask

  initial
  begin
    fetch_pkg::phys_addr_t a;
    fetch_pkg::seg_t rnd_cs;
    fetch_pkg::ofs_t rnd_ip;
    rst = 1'b1;
    start = 1'b0;
    start_cs = '0;
    start_ip = '0;
    mem_valid = 1'b0;
    mem_data = '0;
    mem_busy = 1'b0;
    mem_cnt = 0;
    mem_paddr = '0;
    checking = 1'b0;
    exp_addr = '0;
    dec_count = 0;
    test_errors = 0;
    errors = 0;
    checks = 0;
    tests = 0;
    cycles = 0;
    for (int i = 0; i < 1024; i++)
      mem[i] = 8'(i ^ (i >> 3) ^ 8'h5c);
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_name = "idle";
    test_errors = 0;
    repeat (20)
    begin
      @(posedge clk);
      checks++;
      assert (!mem_req && !dec_valid)
      else
      begin
        $display("idle: fetch or decode became active before any start");
        errors++;
        test_errors++;
      end
    end
    $display("test %s: %0d errors", test_name, test_errors);
    tests++;

    begin_test("classes");
    prog = {8'h01, 8'hd8, 8'h05, 8'h34, 8'h12, 8'h04, 8'hf0, 8'h80, 8'hc1, 8'h85,
            8'h81, 8'he9, 8'h78, 8'h56, 8'h83, 8'hf8, 8'hfe, 8'h8b, 8'hc3, 8'hb3,
            8'h7f, 8'hbc, 8'h00, 8'h80, 8'h43, 8'h5a, 8'h74, 8'hfc, 8'heb, 8'h80,
            8'he9, 8'h34, 8'h12, 8'he8, 8'h00, 8'h01, 8'h90, 8'hc3, 8'hf4, 8'h0f};
    load(20'h00000);
    @(posedge clk);
    launch_now(16'h0000, 16'h0000);
    finish_test(19);

    begin_test("displacement");
    prog = {8'h8b, 8'h06, 8'h34, 8'h12, 8'h8b, 8'h07, 8'h89, 8'h47, 8'h80,
            8'h89, 8'h47, 8'h7f, 8'h03, 8'h88, 8'hcd, 8'hab, 8'h01, 8'hc8,
            8'h81, 8'h46, 8'hf0, 8'h11, 8'h22, 8'h80, 8'h86, 8'h00, 8'h10, 8'hff};
    load(20'h10100);
    @(posedge clk);
    launch_now(16'h1000, 16'h0100);
    finish_test(8);

    begin_test("prefixes");
    prog = {8'h26, 8'h8b, 8'h07, 8'hf3, 8'h90, 8'hf2, 8'hf3, 8'h2e, 8'h3e, 8'h01,
            8'hd8, 8'h36, 8'hf2, 8'hb8, 8'h01, 8'h00, 8'h26, 8'h2e, 8'h36, 8'h3e,
            8'h26, 8'hf2, 8'hf3, 8'hf2, 8'hc3};
    load(20'h00180);
    @(posedge clk);
    launch_now(16'h0010, 16'h0080);
    finish_test(5);

    begin_test("random");
    gen_rng = xorshift(gen_rng);
    rnd_cs = gen_rng[15:0];
    rnd_ip = gen_rng[31:16];
    a = {rnd_cs, 4'h0} + {4'h0, rnd_ip};
    for (int i = 0; i < 200; i++)
      gen_instr(a);
    @(posedge clk);
    launch_now(rnd_cs, rnd_ip);
    finish_test(200);

    begin_test("restart");
    prog = {8'h81, 8'h86, 8'h34, 8'h12, 8'h78, 8'h56, 8'h90};
    load(20'h00300);
    prog = {8'h90, 8'h40, 8'hb0, 8'h11, 8'hf4};
    load(20'h00340);
    @(posedge clk);
    launch_now(16'h0030, 16'h0000);
    // restart once the fourth byte of the long instruction is requested
    do
      @(posedge clk);
    while (!(mem_req && mem_addr == 20'h00303));
    launch_now(16'h0034, 16'h0000);
    finish_test(4);

    errors += DUT.u_sva.failures;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verification
src/fetch_pkg.sv
src/opcode_classify.sv
src/byte_fetch.sv
src/instr_assemble.sv
src/micro_decode.sv
src/fetch_decode_top.sv
verification/fetch_decode_sva.sv
verification/fetch_decode_tb.sv
